/* hw/fetch_pkg.sv */
/*
 * fetch stage package
 * widths, debug addresses, buffer depths and PC source selectors
 */
package fetch_pkg;

  // instruction address and word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // vectored interrupt index inside mtvec
  typedef logic [4:0] irq_vec_t;

  // debug module entry points
  localparam addr_t DM_HALT_ADDR      = 32'h1A11_0800;
  localparam addr_t DM_EXCEPTION_ADDR = 32'h1A11_0808;

  // all internal interrupts share the nmi vector slot
  localparam irq_vec_t IRQ_NM_VEC = 5'd31;

  // word fetch only, no compressed path
  localparam addr_t FETCH_STEP = 32'd4;

  // buffer sizing
  localparam int unsigned FIFO_DEPTH      = 3;
  localparam int unsigned MAX_OUTSTANDING = 2;

  localparam int unsigned FIFO_CNT_W  = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned FIFO_PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned OUTST_CNT_W = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned OUTST_PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  typedef logic [FIFO_CNT_W-1:0]  fifo_cnt_t;
  typedef logic [FIFO_PTR_W-1:0]  fifo_ptr_t;
  typedef logic [OUTST_CNT_W-1:0] outst_cnt_t;
  typedef logic [OUTST_PTR_W-1:0] outst_ptr_t;

  // source of the next PC on a redirect
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception vector kind
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

endpackage

/* hw/pc_select.sv */
`timescale 1ns/1ps

/*
 * next PC selection
 * builds the exception vector and picks the redirect target by source
 */
module pc_select import fetch_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    exc_cause_i,
  input  logic        irq_int_i,
  input  addr_t       boot_addr_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  output addr_t       target_o
);

  irq_vec_t irq_vec;
  addr_t    exc_pc;
  addr_t    sel_pc;

  // internal interrupts all land on the nmi slot
  assign irq_vec = irq_int_i ? IRQ_NM_VEC : exc_cause_i;

  //////////////////////////////
  // exception vector
  //////////////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      // direct mode base
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:2], 2'b00};
      // vectored slot, 4 bytes per cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXCEPTION_ADDR;
      default:        exc_pc = {csr_mtvec_i[31:2], 2'b00};
    endcase
  end

  //////////////////////////////
  // target mux
  //////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: sel_pc = boot_addr_i;
      PC_JUMP: sel_pc = branch_target_i;
      PC_EXC:  sel_pc = exc_pc;
      // return from trap
      PC_ERET: sel_pc = csr_mepc_i;
      // return from debug mode
      PC_DRET: sel_pc = csr_depc_i;
      default: sel_pc = boot_addr_i;
    endcase
  end

  // word fetch only so the target is always word aligned
  assign target_o = {sel_pc[31:2], 2'b00};

endmodule

/* hw/fetch_requester.sv */
`timescale 1ns/1ps

/*
 * fetch requester
 * issues word requests on the instruction bus, tags each response with its
 * address and drops responses that belong to the stream before a redirect
 */
module fetch_requester import fetch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      pc_set_i,
  input  addr_t     target_i,
  input  logic      instr_gnt_i,
  input  logic      instr_rvalid_i,
  input  instr_t    instr_rdata_i,
  input  logic      instr_bus_err_i,
  input  fifo_cnt_t fifo_count_i,
  output logic      instr_req_o,
  output addr_t     instr_addr_o,
  output logic      push_o,
  output addr_t     push_addr_o,
  output instr_t    push_data_o,
  output logic      push_err_o,
  output logic      busy_o
);

  logic                  en_q;
  addr_t                 addr_q, addr_d;
  addr_t                 redir_addr_q, redir_addr_d;
  logic                  stale_q, stale_d;
  outst_cnt_t            outst_q, outst_d;
  outst_cnt_t            drop_q, drop_d;
  addr_t                 tag_q [MAX_OUTSTANDING];
  outst_ptr_t            tag_wr_q, tag_rd_q;
  logic [FIFO_CNT_W:0]   fill;
  logic                  handoff;
  logic                  dropping;

  function automatic outst_ptr_t next_ptr(input outst_ptr_t ptr);
    if (ptr == outst_ptr_t'(MAX_OUTSTANDING - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////
  // request side
  //////////////////////////////

  // words in flight plus words already buffered
  assign fill = {1'b0, fifo_count_i} + (FIFO_CNT_W + 1)'(outst_q);

  // credit only shrinks on a grant so a raised request holds until handoff
  assign instr_req_o  = en_q & (outst_q < MAX_OUTSTANDING) & (fill < FIFO_DEPTH);
  assign instr_addr_o = addr_q;
  assign handoff      = instr_req_o & instr_gnt_i;

  assign outst_d = outst_q + outst_cnt_t'(handoff) - outst_cnt_t'(instr_rvalid_i);

  always_comb begin
    addr_d       = addr_q;
    redir_addr_d = redir_addr_q;
    stale_d      = stale_q;
    drop_d       = drop_q;
    // after a handoff continue the stream or take the deferred target
    if (handoff) begin
      addr_d  = stale_q ? redir_addr_q : addr_q + FETCH_STEP;
      stale_d = 1'b0;
    end
    if (instr_rvalid_i && dropping) begin
      drop_d = drop_d - 1'b1;
    end
    // a stale request that just went out also owes a dropped response
    if (handoff && stale_q) begin
      drop_d = drop_d + 1'b1;
    end
    if (pc_set_i) begin
      // everything still unanswered after this edge is from the old stream
      drop_d = outst_d;
      if (instr_req_o && !instr_gnt_i) begin
        // bus address must hold so park the target until the grant
        stale_d      = 1'b1;
        redir_addr_d = target_i;
      end else begin
        addr_d = target_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q         <= 1'b0;
      addr_q       <= '0;
      redir_addr_q <= '0;
      stale_q      <= 1'b0;
      outst_q      <= '0;
      drop_q       <= '0;
    end else begin
      // idle until the first redirect
      en_q         <= en_q | pc_set_i;
      addr_q       <= addr_d;
      redir_addr_q <= redir_addr_d;
      stale_q      <= stale_d;
      outst_q      <= outst_d;
      drop_q       <= drop_d;
    end
  end

  //////////////////////////////
  // response side
  //////////////////////////////

  // in-order address tags, one per granted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MAX_OUTSTANDING; i++) begin
        tag_q[i] <= '0;
      end
      tag_wr_q <= '0;
      tag_rd_q <= '0;
    end else begin
      if (handoff) begin
        tag_q[tag_wr_q] <= addr_q;
        tag_wr_q        <= next_ptr(tag_wr_q);
      end
      if (instr_rvalid_i) begin
        tag_rd_q <= next_ptr(tag_rd_q);
      end
    end
  end

  assign dropping = (drop_q != '0);

  // the FIFO write registers the push
  assign push_o      = instr_rvalid_i & ~dropping;
  assign push_addr_o = tag_q[tag_rd_q];
  assign push_data_o = instr_rdata_i;
  assign push_err_o  = instr_bus_err_i;

  assign busy_o = instr_req_o | (outst_q != '0);

endmodule

/* hw/fetch_fifo.sv */
`timescale 1ns/1ps

/*
 * fetch FIFO
 * circular buffer of fetched words with address and error, flushed on redirect
 */
module fetch_fifo import fetch_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  logic      push_i,
  input  addr_t     push_addr_i,
  input  instr_t    push_data_i,
  input  logic      push_err_i,
  input  logic      pop_i,
  output logic      valid_o,
  output addr_t     addr_o,
  output instr_t    data_o,
  output logic      err_o,
  output fifo_cnt_t count_o
);

  addr_t     addr_q [FIFO_DEPTH];
  instr_t    data_q [FIFO_DEPTH];
  logic      err_q  [FIFO_DEPTH];
  fifo_ptr_t rd_ptr_q, wr_ptr_q;
  fifo_cnt_t count_q;
  logic      do_push;
  logic      do_pop;

  function automatic fifo_ptr_t next_ptr(input fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // flush wins over a push in the same cycle
  assign do_push = push_i & ~flush_i;
  assign do_pop  = pop_i & valid_o & ~flush_i;

  //////////////////////////////
  // pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
    end
  end

  // entry storage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < FIFO_DEPTH; i++) begin
        addr_q[i] <= '0;
        data_q[i] <= '0;
        err_q[i]  <= 1'b0;
      end
    end else if (do_push) begin
      addr_q[wr_ptr_q] <= push_addr_i;
      data_q[wr_ptr_q] <= push_data_i;
      err_q[wr_ptr_q]  <= push_err_i;
    end
  end

  // head entry, no bypass from the push side
  assign valid_o = (count_q != '0);
  assign addr_o  = addr_q[rd_ptr_q];
  assign data_o  = data_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

/* hw/if_id_register.sv */
`timescale 1ns/1ps

/*
 * IF-ID pipeline register
 * takes the FIFO head when ID is ready and flags valid and new instructions
 */
module if_id_register import fetch_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  addr_t  fetch_addr_i,
  input  instr_t fetch_data_i,
  input  logic   fetch_err_i,
  input  logic   pmp_err_if_i,
  input  logic   id_in_ready_i,
  input  logic   pc_set_i,
  input  logic   instr_valid_clear_i,
  output logic   fifo_pop_o,
  output logic   instr_valid_id_o,
  output logic   instr_new_id_o,
  output instr_t instr_rdata_id_o,
  output logic   instr_fetch_err_o,
  output addr_t  pc_id_o,
  output addr_t  pc_if_o
);

  logic valid_d;

  // a redirect squashes the head in that cycle
  assign fifo_pop_o = fetch_valid_i & id_in_ready_i & ~pc_set_i;

  // valid holds until ID clears it
  assign valid_d = fifo_pop_o | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      instr_valid_id_o <= valid_d;
      // one cycle pulse after each pop
      instr_new_id_o   <= fifo_pop_o;
      if (fifo_pop_o) begin
        instr_rdata_id_o  <= fetch_data_i;
        // bus and pmp faults both report as a fetch error
        instr_fetch_err_o <= fetch_err_i | pmp_err_if_i;
        pc_id_o           <= fetch_addr_i;
      end
    end
  end

  assign pc_if_o = fetch_addr_i;

endmodule

/* hw/if_stage.sv */
`timescale 1ns/1ps

/*
 * instruction fetch stage
 * PC select, bus requester, fetch FIFO and IF-ID register
 */
module if_stage import fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  addr_t       boot_addr_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  irq_vec_t    exc_cause_i,
  input  logic        irq_int_i,
  input  addr_t       branch_target_i,
  input  addr_t       csr_mepc_i,
  input  addr_t       csr_depc_i,
  input  addr_t       csr_mtvec_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  instr_t      instr_rdata_i,
  input  logic        instr_bus_err_i,
  input  logic        pmp_err_if_i,
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  output logic        instr_req_o,
  output addr_t       instr_addr_o,
  output addr_t       pc_set_target_o,
  output logic        csr_mtvec_init_o,
  output logic        if_busy_o,
  output logic        fifo_pop_o,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output instr_t      instr_rdata_id_o,
  output logic        instr_fetch_err_o,
  output addr_t       pc_id_o,
  output addr_t       pc_if_o
);

  addr_t     target;
  logic      push;
  addr_t     push_addr;
  instr_t    push_data;
  logic      push_err;
  logic      fifo_valid;
  addr_t     fifo_addr;
  instr_t    fifo_data;
  logic      fifo_err;
  fifo_cnt_t fifo_count;
  logic      fetch_busy;

  pc_select pc_select_i (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_cause_i     (exc_cause_i),
    .irq_int_i       (irq_int_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_depc_i      (csr_depc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .target_o        (target)
  );

  fetch_requester fetch_requester_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pc_set_i        (pc_set_i),
    .target_i        (target),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .fifo_count_i    (fifo_count),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .push_o          (push),
    .push_addr_o     (push_addr),
    .push_data_o     (push_data),
    .push_err_o      (push_err),
    .busy_o          (fetch_busy)
  );

  // redirect flushes buffered words of the old stream
  fetch_fifo fetch_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (pc_set_i),
    .push_i      (push),
    .push_addr_i (push_addr),
    .push_data_i (push_data),
    .push_err_i  (push_err),
    .pop_i       (fifo_pop_o),
    .valid_o     (fifo_valid),
    .addr_o      (fifo_addr),
    .data_o      (fifo_data),
    .err_o       (fifo_err),
    .count_o     (fifo_count)
  );

  if_id_register if_id_register_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fifo_valid),
    .fetch_addr_i        (fifo_addr),
    .fetch_data_i        (fifo_data),
    .fetch_err_i         (fifo_err),
    .pmp_err_if_i        (pmp_err_if_i),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fifo_pop_o          (fifo_pop_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_if_o             (pc_if_o)
  );

  // CSR file loads mtvec from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);
  assign pc_set_target_o  = target;
  assign if_busy_o        = fetch_busy;

endmodule

/* bench/if_stage_tb.sv */
`timescale 1ns/1ps

/*
 * testbench for the instruction fetch stage
 * random bus memory, random redirects, concurrent checks with error counting
 */
module if_stage_tb import fetch_pkg::*; ();

  localparam int     NUM_REDIRECTS = 40;
  localparam addr_t  DATA_XOR      = 32'hA5A5_0000;
  localparam logic [31:0] SEED     = 32'h79d5b290;

  logic        clk_i               = 1'b0;
  logic        rst_ni              = 1'b0;
  addr_t       boot_addr_i         = '0;
  logic        pc_set_i            = 1'b0;
  pc_sel_e     pc_mux_i            = PC_BOOT;
  exc_pc_sel_e exc_pc_mux_i        = EXC_PC_EXC;
  irq_vec_t    exc_cause_i         = '0;
  logic        irq_int_i           = 1'b0;
  addr_t       branch_target_i     = '0;
  addr_t       csr_mepc_i          = '0;
  addr_t       csr_depc_i          = '0;
  addr_t       csr_mtvec_i         = '0;
  logic        instr_gnt_i         = 1'b0;
  logic        instr_rvalid_i      = 1'b0;
  instr_t      instr_rdata_i       = '0;
  logic        instr_bus_err_i     = 1'b0;
  logic        pmp_err_if_i        = 1'b0;
  logic        id_in_ready_i       = 1'b0;
  logic        instr_valid_clear_i = 1'b0;

  logic        instr_req_o;
  addr_t       instr_addr_o;
  addr_t       pc_set_target_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;
  logic        fifo_pop_o;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  instr_t      instr_rdata_id_o;
  logic        instr_fetch_err_o;
  addr_t       pc_id_o;
  addr_t       pc_if_o;

  // reference model state
  addr_t       stream_pc;
  addr_t       head_pc;
  addr_t       exp_target;
  logic        exp_err;
  logic        pmp_prev;
  logic        pop_prev;
  logic        seen_set;
  int          unanswered;
  int          errors;
  int          instr_count;
  int          redirects;

  // memory model state
  addr_t       pend_q [$];
  int          resp_wait;

  if_stage if_stage_i (.*);

  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // helpers
  //////////////////////////////

  // windows near the bus error range so both cases show up
  function automatic addr_t rand_addr();
    return 32'h0000_2F00 + addr_t'(($urandom % 256) * 4);
  endfunction

  function automatic logic in_err_window(input addr_t a);
    return (a >= 32'h0000_3000) && (a <= 32'h0000_30FF);
  endfunction

  function automatic addr_t redirect_target(
    input pc_sel_e sel, input exc_pc_sel_e exc, input irq_vec_t cause, input logic irq_int,
    input addr_t boot, input addr_t jump, input addr_t mepc, input addr_t depc,
    input addr_t mtvec
  );
    addr_t    vec_base;
    addr_t    t;
    irq_vec_t idx;
    idx = irq_int ? IRQ_NM_VEC : cause;
    case (exc)
      EXC_PC_IRQ:     vec_base = (mtvec & 32'hFFFF_FF00) | (addr_t'(idx) << 2);
      EXC_PC_DBD:     vec_base = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: vec_base = DM_EXCEPTION_ADDR;
      default:        vec_base = mtvec & ~32'h3;
    endcase
    case (sel)
      PC_JUMP: t = jump;
      PC_EXC:  t = vec_base;
      PC_ERET: t = mepc;
      PC_DRET: t = depc;
      default: t = boot;
    endcase
    return t & ~32'h3;
  endfunction

  // one cycle redirect pulse with fresh CSR values
  task automatic issue_redirect(input logic boot);
    @(posedge clk_i);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= boot ? PC_BOOT : pc_sel_e'($urandom % 5);
    exc_pc_mux_i    <= exc_pc_sel_e'($urandom % 4);
    exc_cause_i     <= irq_vec_t'($urandom);
    irq_int_i       <= 1'($urandom);
    boot_addr_i     <= rand_addr();
    branch_target_i <= rand_addr();
    csr_mepc_i      <= rand_addr();
    csr_depc_i      <= rand_addr();
    csr_mtvec_i     <= rand_addr();
    @(posedge clk_i);
    pc_set_i        <= 1'b0;
  endtask

  task automatic wait_instructions(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(posedge clk_i);
      if (instr_new_id_o) begin
        seen++;
      end
    end
  endtask

  //////////////////////////////
  // bus memory and ID side
  //////////////////////////////

  // grants at random, answers in order after a random delay
  always @(posedge clk_i) begin
    addr_t a;
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      pend_q.delete();
      resp_wait      = 0;
    end else begin
      instr_gnt_i    <= ($urandom % 4) != 0;
      instr_rvalid_i <= 1'b0;
      if (instr_req_o && instr_gnt_i) begin
        pend_q.push_back(instr_addr_o);
      end
      if (resp_wait != 0) begin
        resp_wait = resp_wait - 1;
      end else if (pend_q.size() > 0) begin
        a = pend_q.pop_front();
        instr_rvalid_i  <= 1'b1;
        instr_rdata_i   <= a ^ DATA_XOR;
        instr_bus_err_i <= in_err_window(a);
        resp_wait       = $urandom % 3;
      end
    end
  end

  always @(posedge clk_i) begin
    id_in_ready_i       <= ($urandom % 4) != 0;
    pmp_err_if_i        <= ($urandom % 8) == 0;
    instr_valid_clear_i <= 1'($urandom);
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  always_comb begin
    exp_target = redirect_target(pc_mux_i, exc_pc_mux_i, exc_cause_i, irq_int_i, boot_addr_i,
                                 branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i);
  end

  assign exp_err = in_err_window(stream_pc) | pmp_prev;

  // the word landing in ID this cycle still counts as the current stream pc
  assign head_pc = instr_new_id_o ? stream_pc + FETCH_STEP : stream_pc;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stream_pc   <= '0;
      pmp_prev    <= 1'b0;
      pop_prev    <= 1'b0;
      seen_set    <= 1'b0;
      unanswered  <= 0;
      instr_count <= 0;
    end else begin
      // pmp of the pop cycle lands with the new instruction
      pmp_prev <= pmp_err_if_i;
      pop_prev <= fifo_pop_o;
      if (instr_req_o && instr_gnt_i && !instr_rvalid_i) begin
        unanswered <= unanswered + 1;
      end else if (!(instr_req_o && instr_gnt_i) && instr_rvalid_i) begin
        unanswered <= unanswered - 1;
      end
      if (pc_set_i) begin
        stream_pc <= exp_target;
        seen_set  <= 1'b1;
      end else if (instr_new_id_o) begin
        stream_pc <= stream_pc + FETCH_STEP;
      end
      if (instr_new_id_o) begin
        instr_count <= instr_count + 1;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_rdata_id_o == (stream_pc ^ DATA_XOR))
  else begin
    errors++;
    $display("ERROR instr_rdata_id_o got %h exp %h", $sampled(instr_rdata_id_o),
             $sampled(stream_pc) ^ DATA_XOR);
  end

  a_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_id_o == stream_pc)
  else begin
    errors++;
    $display("ERROR pc_id_o got %h exp %h", $sampled(pc_id_o), $sampled(stream_pc));
  end

  a_err: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_fetch_err_o == exp_err)
  else begin
    errors++;
    $display("ERROR instr_fetch_err_o got %h exp %h", $sampled(instr_fetch_err_o),
             $sampled(exp_err));
  end

  a_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |-> pc_set_target_o == exp_target)
  else begin
    errors++;
    $display("ERROR pc_set_target_o got %h exp %h", $sampled(pc_set_target_o),
             $sampled(exp_target));
  end

  // one new flag for each pop, in the following cycle
  a_new_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o == pop_prev)
  else begin
    errors++;
    $display("ERROR instr_new_id_o got %h exp %h", $sampled(instr_new_id_o),
             $sampled(pop_prev));
  end

  a_pop_cond: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_pop_o |-> id_in_ready_i && !pc_set_i)
  else begin
    errors++;
    $display("head popped while ID was not ready or during a redirect");
  end

  a_pc_if: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_pop_o |-> pc_if_o == head_pc)
  else begin
    errors++;
    $display("ERROR pc_if_o got %h exp %h", $sampled(pc_if_o), $sampled(head_pc));
  end

  // bus request must hold until its grant
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
  else begin
    errors++;
    $display("request dropped or address changed before its grant");
  end

  a_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
  else begin
    errors++;
    $display("ERROR instr_addr_o got %h, not word aligned", $sampled(instr_addr_o));
  end

  a_outst: assert property (@(posedge clk_i) disable iff (!rst_ni)
    unanswered <= int'(MAX_OUTSTANDING))
  else begin
    errors++;
    $display("more grants unanswered than the bus allows");
  end

  a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    if_busy_o == (instr_req_o || unanswered != 0))
  else begin
    errors++;
    $display("ERROR if_busy_o got %h exp %h", $sampled(if_busy_o),
             $sampled(instr_req_o || unanswered != 0));
  end

  a_mtvec: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
  else begin
    errors++;
    $display("ERROR csr_mtvec_init_o got %h exp %h", $sampled(csr_mtvec_init_o),
             $sampled(pc_set_i && pc_mux_i == PC_BOOT));
  end

  a_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o && !instr_valid_clear_i |=> instr_valid_id_o)
  else begin
    errors++;
    $display("instr_valid_id_o fell without a clear");
  end

  a_valid_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o && instr_valid_clear_i && !fifo_pop_o |=> !instr_valid_id_o)
  else begin
    errors++;
    $display("instr_valid_id_o stayed high after a clear");
  end

  a_new_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o)
  else begin
    errors++;
    $display("new instruction flagged without valid");
  end

  // covers the reset cycles too
  a_idle: assert property (@(posedge clk_i)
    !seen_set |-> !instr_req_o && !instr_valid_id_o && !instr_new_id_o && !if_busy_o)
  else begin
    errors++;
    $display("control output active before the first redirect");
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    errors    = 0;
    redirects = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    issue_redirect(1'b1);
    redirects++;
    wait_instructions(4);
    while (redirects < NUM_REDIRECTS) begin
      issue_redirect(1'b0);
      redirects++;
      // zero waits redirect while the old stream is still in flight
      wait_instructions($urandom % 6);
      repeat ($urandom % 4) @(posedge clk_i);
    end
    wait_instructions(4);
    repeat (2) @(posedge clk_i);
    $display("redirects %0d, instructions %0d, errors %0d", redirects, instr_count, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog sized from the redirect count
  initial begin
    repeat (NUM_REDIRECTS * 200) @(posedge clk_i);
    $display("timeout, redirect sequence did not finish after %0d cycles",
             NUM_REDIRECTS * 200);
    $display("tests failed");
    $finish;
  end

endmodule

/* list.f */
hw/fetch_pkg.sv
hw/pc_select.sv
hw/fetch_requester.sv
hw/fetch_fifo.sv
hw/if_id_register.sv
hw/if_stage.sv
bench/if_stage_tb.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/Vif_stage_tb

obj_dir/Vif_stage_tb: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module if_stage_tb \
		-f list.f -Mdir obj_dir -o Vif_stage_tb

run: obj_dir/Vif_stage_tb
	@out="$$(./obj_dir/Vif_stage_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
